/* msx_bus_pkg.sv */
package msx_bus_pkg;

	// ----------------------------------------------------------
	// slot bus widths
	// ----------------------------------------------------------

	// full Z80 address as seen on the cartridge slot
	typedef logic [15:0] bus_addr_t;

	// one data byte on td
	typedef logic [7:0] bus_data_t;

	// flip-flops between the raw slot pins and clk42 logic
	localparam int unsigned SYNC_STAGES = 2;

	// ----------------------------------------------------------
	// request and response between controller and datapath
	// ----------------------------------------------------------

	// one access, strobes are single clk42 pulses
	// addr and wdata only meaningful while a strobe is high
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic      io_read;
		logic      io_write;
		logic      mem_read;
		logic      mem_write;
	} bus_req_t;

	// read answer from one datapath block
	// ready is a one-cycle pulse, data forced to zero otherwise
	// so several answers can simply be ORed together
	typedef struct packed {
		logic      ready;
		bus_data_t data;
	} bus_rsp_t;

endpackage

/* cart_map_pkg.sv */
package cart_map_pkg;

	// ----------------------------------------------------------
	// cartridge memory window
	// ----------------------------------------------------------

	// 1 KiB of block RAM
	localparam int unsigned RAM_ADDR_W = 10;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

	// page 1 of the slot, RAM mirrored by its low address bits
	localparam msx_bus_pkg::bus_addr_t RAM_BASE  = 16'h4000;
	localparam msx_bus_pkg::bus_addr_t RAM_LIMIT = 16'h7FFF;

	// ----------------------------------------------------------
	// I/O ports, decoded on the low 8 address bits only
	// ----------------------------------------------------------

	// write sets the LED outputs, read returns the general inputs
	localparam logic [7:0] PORT_GPIO  = 8'h10;
	// write sets the sound level, read returns it
	localparam logic [7:0] PORT_SOUND = 8'h11;

	// ----------------------------------------------------------
	// sound PWM
	// ----------------------------------------------------------

	typedef logic [7:0] level_t;

	// clk42 cycles per PWM step, about 1.59 MHz
	localparam int unsigned PWM_TICK_DIV = 27;
	typedef logic [4:0] pwm_cnt_t;

endpackage

/* cart_bus_ctrl.sv */
`timescale 1ns/1ps

module cart_bus_ctrl (
	input  logic                   clk42,
	input  logic                   w_n_reset,
	input  msx_bus_pkg::bus_addr_t ta,
	input  msx_bus_pkg::bus_data_t td_in,
	input  logic                   n_sltsl,
	input  logic                   n_merq,
	input  logic                   n_iorq,
	input  logic                   n_rd,
	input  logic                   n_wr,
	input  msx_bus_pkg::bus_rsp_t  ram_rsp,
	input  msx_bus_pkg::bus_rsp_t  io_rsp,
	output msx_bus_pkg::bus_req_t  req,
	output msx_bus_pkg::bus_data_t td_out,
	output logic                   tdir
);
	localparam int unsigned STAGES = msx_bus_pkg::SYNC_STAGES;

	// synchronizer chains, stage 0 sees the raw pins
	msx_bus_pkg::bus_addr_t addr_sync [STAGES];
	msx_bus_pkg::bus_data_t data_sync [STAGES];
	// {n_sltsl, n_merq, n_iorq, n_rd, n_wr}
	logic [4:0]             strb_sync [STAGES];

	logic sltsl_n_s, merq_n_s, iorq_n_s, rd_n_s, wr_n_s;
	logic rd_prev, wr_prev;
	logic rd_fall, wr_fall;
	logic is_io, is_mem;

	// captured request
	msx_bus_pkg::bus_addr_t req_addr_q;
	msx_bus_pkg::bus_data_t req_data_q;
	logic [3:0]             req_strb_q;

	logic                   rsp_ready;
	msx_bus_pkg::bus_data_t rsp_data;
	msx_bus_pkg::bus_data_t rd_data_q;
	logic                   drive_q;

	// ----------------------------------------------------------
	// pin synchronizers
	// ----------------------------------------------------------

	// address and data follow the strobes with equal delay
	always_ff @(posedge clk42) begin
		addr_sync[0] <= ta;
		data_sync[0] <= td_in;
		for (int i = 1; i < STAGES; i++) begin
			addr_sync[i] <= addr_sync[i-1];
			data_sync[i] <= data_sync[i-1];
		end
	end

	// strobes idle high
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			for (int i = 0; i < STAGES; i++) begin
				strb_sync[i] <= '1;
			end
			rd_prev <= 1'b1;
			wr_prev <= 1'b1;
		end else begin
			strb_sync[0] <= {n_sltsl, n_merq, n_iorq, n_rd, n_wr};
			for (int i = 1; i < STAGES; i++) begin
				strb_sync[i] <= strb_sync[i-1];
			end
			rd_prev <= rd_n_s;
			wr_prev <= wr_n_s;
		end
	end

	assign {sltsl_n_s, merq_n_s, iorq_n_s, rd_n_s, wr_n_s} = strb_sync[STAGES-1];

	// ----------------------------------------------------------
	// access classification
	// ----------------------------------------------------------

	assign rd_fall = rd_prev & ~rd_n_s;
	assign wr_fall = wr_prev & ~wr_n_s;
	assign is_io   = ~iorq_n_s;
	// memory only counts when our slot is selected
	assign is_mem  = ~merq_n_s & ~sltsl_n_s;

	// payload, no reset
	always_ff @(posedge clk42) begin
		req_addr_q <= addr_sync[STAGES-1];
		req_data_q <= data_sync[STAGES-1];
	end

	// one pulse per strobe edge, order io_read io_write mem_read mem_write
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			req_strb_q <= '0;
		end else begin
			req_strb_q <= {rd_fall & is_io, wr_fall & is_io,
				rd_fall & is_mem, wr_fall & is_mem};
		end
	end

	assign req.addr      = req_addr_q;
	assign req.wdata     = req_data_q;
	assign req.io_read   = req_strb_q[3];
	assign req.io_write  = req_strb_q[2];
	assign req.mem_read  = req_strb_q[1];
	assign req.mem_write = req_strb_q[0];

	// ----------------------------------------------------------
	// read data return
	// ----------------------------------------------------------

	// data is zero while not ready, OR merge is safe
	assign rsp_ready = ram_rsp.ready | io_rsp.ready;
	assign rsp_data  = ram_rsp.data | io_rsp.data;

	always_ff @(posedge clk42) begin
		if (rsp_ready) begin
			rd_data_q <= rsp_data;
		end
	end

	// drive from the cycle after ready until synced n_rd goes high
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			drive_q <= 1'b0;
		end else if (rsp_ready) begin
			drive_q <= 1'b1;
		end else if (rd_n_s) begin
			drive_q <= 1'b0;
		end
	end

	assign td_out = rd_data_q;
	assign tdir   = drive_q;

	// two datapath blocks never answer the same access
	assert property (@(posedge clk42) disable iff (!w_n_reset)
		!(ram_rsp.ready && io_rsp.ready))
		else $error("ram and io ready high together");

	// an answer only follows a read request
	assert property (@(posedge clk42) disable iff (!w_n_reset)
		rsp_ready |-> $past(req.io_read || req.mem_read))
		else $error("ready without a preceding read request");

endmodule

/* cart_ram.sv */
`timescale 1ns/1ps

module cart_ram (
	input  logic                  clk42,
	input  logic                  w_n_reset,
	input  msx_bus_pkg::bus_req_t req,
	output msx_bus_pkg::bus_rsp_t rsp
);
	localparam int unsigned DEPTH = 2 ** cart_map_pkg::RAM_ADDR_W;

	msx_bus_pkg::bus_data_t mem [DEPTH];

	logic                   hit;
	cart_map_pkg::ram_addr_t idx;
	msx_bus_pkg::bus_data_t rd_q;
	logic                   ready_q;

	// whole page 1 window, low bits select the byte
	assign hit = (req.addr >= cart_map_pkg::RAM_BASE) &&
		(req.addr <= cart_map_pkg::RAM_LIMIT);
	assign idx = req.addr[cart_map_pkg::RAM_ADDR_W-1:0];

	// array and read register, contents survive reset
	always_ff @(posedge clk42) begin
		if (req.mem_write && hit) begin
			mem[idx] <= req.wdata;
		end
		rd_q <= mem[idx];
	end

	// answer one cycle after a window read
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= req.mem_read & hit;
		end
	end

	assign rsp.ready = ready_q;
	// zero outside the pulse
	assign rsp.data  = ready_q ? rd_q : '0;

	// single pulse right after a read request
	assert property (@(posedge clk42) disable iff (!w_n_reset)
		rsp.ready |-> $past(req.mem_read) && !$past(rsp.ready))
		else $error("ram ready without mem_read or longer than one cycle");

endmodule

/* cart_io_regs.sv */
`timescale 1ns/1ps

module cart_io_regs (
	input  logic                   clk42,
	input  logic                   w_n_reset,
	input  msx_bus_pkg::bus_req_t  req,
	input  msx_bus_pkg::bus_data_t gpi,
	output msx_bus_pkg::bus_rsp_t  rsp,
	output msx_bus_pkg::bus_data_t gpo,
	output cart_map_pkg::level_t   sound_level
);
	logic                   sel_gpio, sel_sound;
	msx_bus_pkg::bus_data_t gpo_q;
	cart_map_pkg::level_t   level_q;
	msx_bus_pkg::bus_data_t rd_q;
	logic                   ready_q;

	// ----------------------------------------------------------
	// port decode, low address byte only
	// ----------------------------------------------------------

	assign sel_gpio  = req.addr[7:0] == cart_map_pkg::PORT_GPIO;
	assign sel_sound = req.addr[7:0] == cart_map_pkg::PORT_SOUND;

	// output registers
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			gpo_q   <= '0;
			level_q <= '0;
		end else if (req.io_write) begin
			if (sel_gpio) begin
				gpo_q <= req.wdata;
			end
			if (sel_sound) begin
				level_q <= req.wdata;
			end
		end
	end

	// readback, gpi sampled at the request
	always_ff @(posedge clk42) begin
		rd_q <= sel_gpio ? gpi : level_q;
	end

	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= req.io_read & (sel_gpio | sel_sound);
		end
	end

	assign rsp.ready   = ready_q;
	assign rsp.data    = ready_q ? rd_q : '0;
	assign gpo         = gpo_q;
	assign sound_level = level_q;

	// single pulse right after a read request
	assert property (@(posedge clk42) disable iff (!w_n_reset)
		rsp.ready |-> $past(req.io_read) && !$past(rsp.ready))
		else $error("io ready without io_read or longer than one cycle");

endmodule

/* pwm_dac.sv */
`timescale 1ns/1ps

module pwm_dac (
	input  logic                 clk42,
	input  logic                 w_n_reset,
	input  cart_map_pkg::level_t level,
	output logic                 tsnd
);
	localparam cart_map_pkg::pwm_cnt_t DIV_LAST =
		cart_map_pkg::pwm_cnt_t'(cart_map_pkg::PWM_TICK_DIV - 1);

	cart_map_pkg::pwm_cnt_t div_q;
	logic                   tick;
	cart_map_pkg::level_t   phase_q;
	cart_map_pkg::level_t   level_q;
	logic                   tsnd_q;

	// one tick every PWM_TICK_DIV clocks
	assign tick = div_q == DIV_LAST;

	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			div_q   <= '0;
			phase_q <= '0;
			level_q <= '0;
			tsnd_q  <= 1'b0;
		end else begin
			div_q <= tick ? '0 : div_q + 1'b1;
			if (tick) begin
				phase_q <= phase_q + 1'b1;
				// new level only at the period boundary
				if (phase_q == '1) begin
					level_q <= level;
				end
			end
			tsnd_q <= phase_q < level_q;
		end
	end

	// high for level ticks out of 256
	assign tsnd = tsnd_q;

endmodule

/* tangcart_top.sv */
`timescale 1ns/1ps

module tangcart_top (
	input  logic                   clk42,
	input  logic                   w_n_reset,
	input  msx_bus_pkg::bus_addr_t ta,
	input  logic                   n_sltsl,
	input  logic                   n_merq,
	input  logic                   n_iorq,
	input  logic                   n_rd,
	input  logic                   n_wr,
	input  msx_bus_pkg::bus_data_t gpi,
	inout  wire [7:0]              td,
	output logic                   tdir,
	output msx_bus_pkg::bus_data_t gpo,
	output logic                   tsnd
);
	msx_bus_pkg::bus_req_t  req;
	msx_bus_pkg::bus_rsp_t  ram_rsp;
	msx_bus_pkg::bus_rsp_t  io_rsp;
	msx_bus_pkg::bus_data_t td_out;
	cart_map_pkg::level_t   sound_level;

	// ----------------------------------------------------------
	// slot bus
	// ----------------------------------------------------------

	cart_bus_ctrl u_ctrl (
		.clk42     (clk42),
		.w_n_reset (w_n_reset),
		.ta        (ta),
		.td_in     (td),
		.n_sltsl   (n_sltsl),
		.n_merq    (n_merq),
		.n_iorq    (n_iorq),
		.n_rd      (n_rd),
		.n_wr      (n_wr),
		.ram_rsp   (ram_rsp),
		.io_rsp    (io_rsp),
		.req       (req),
		.td_out    (td_out),
		.tdir      (tdir)
	);

	// level shifter direction and td drive share one enable
	assign td = tdir ? td_out : 'z;

	// ----------------------------------------------------------
	// datapath
	// ----------------------------------------------------------

	cart_ram u_ram (
		.clk42     (clk42),
		.w_n_reset (w_n_reset),
		.req       (req),
		.rsp       (ram_rsp)
	);

	cart_io_regs u_io (
		.clk42       (clk42),
		.w_n_reset   (w_n_reset),
		.req         (req),
		.gpi         (gpi),
		.rsp         (io_rsp),
		.gpo         (gpo),
		.sound_level (sound_level)
	);

	// sound pin
	pwm_dac u_pwm (
		.clk42     (clk42),
		.w_n_reset (w_n_reset),
		.level     (sound_level),
		.tsnd      (tsnd)
	);

endmodule

/* tb_tangcart.sv */
`timescale 1ns/1ps

module tb_tangcart;

	// local copies of the cartridge map
	localparam logic [15:0] RAM_BASE_TB   = 16'h4000;
	localparam logic [7:0]  PORT_GPIO_TB  = 8'h10;
	localparam logic [7:0]  PORT_SOUND_TB = 8'h11;
	localparam int unsigned TICK_DIV_TB   = 27;
	localparam int unsigned PWM_PERIOD    = 256 * TICK_DIV_TB;

	localparam int unsigned CLK_NS         = 10;
	localparam int unsigned RESET_CYCLES   = 3;
	localparam int unsigned STROBE_CYCLES  = 12;
	localparam int unsigned IDLE_CYCLES    = 6;
	// td drive ends this many cycles after the strobe rises
	localparam int unsigned RELEASE_CYCLES = 3;
	localparam int unsigned ACCESS_CYCLES  = STROBE_CYCLES + IDLE_CYCLES;
	// 45 accesses, 7 PWM periods (reset check plus wait and window per level)
	localparam int unsigned RUN_CYCLES    = 45 * ACCESS_CYCLES + 7 * PWM_PERIOD + 16;
	// twice the expected length
	localparam int unsigned WATCHDOG_NS   = 2 * RUN_CYCLES * CLK_NS;

	typedef enum logic [1:0] {CHK_NONE, CHK_READ, CHK_GPO, CHK_QUIET} chk_t;

	logic        clk42;
	logic        w_n_reset;
	logic [15:0] ta;
	logic        n_sltsl, n_merq, n_iorq, n_rd, n_wr;
	logic [7:0]  gpi;
	wire  [7:0]  td;
	logic        tdir;
	logic [7:0]  gpo;
	logic        tsnd;

	// host side of td
	logic [7:0]  td_drv;
	logic        td_drv_en;

	// check strobes, driven on the falling edge
	logic        chk_reset, chk_rd, chk_gpo, chk_quiet, chk_pwm, chk_release;
	logic [7:0]  exp_byte;
	int unsigned exp_cnt;
	int unsigned high_cnt;
	string       test_name;

	logic [15:0] lfsr;
	logic [7:0]  ram_model [1024];
	logic [15:0] ram_addr_q [16];

	assign td = td_drv_en ? td_drv : 8'hzz;

	tangcart_top DUT (
		.clk42     (clk42),
		.w_n_reset (w_n_reset),
		.ta        (ta),
		.n_sltsl   (n_sltsl),
		.n_merq    (n_merq),
		.n_iorq    (n_iorq),
		.n_rd      (n_rd),
		.n_wr      (n_wr),
		.gpi       (gpi),
		.td        (td),
		.tdir      (tdir),
		.gpo       (gpo),
		.tsnd      (tsnd)
	);

	initial begin
		clk42 = 1'b0;
		forever #(CLK_NS / 2) clk42 = ~clk42;
	end

	// ----------------------------------------------------------
	// failure reporting
	// ----------------------------------------------------------

	task automatic fail_run();
		$display("Regression failed");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic report_value(input string name, input int unsigned expv,
		input int unsigned actv);
		$display("ERROR %s expected %0d actual %0d", name, expv, actv);
		fail_run();
	endtask

	task automatic report_plain(input string what);
		$display("%s: %s", test_name, what);
		fail_run();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("the run timed out after %0d ns without finishing", WATCHDOG_NS);
		fail_run();
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------

	// reset and idle state
	assert property (@(posedge clk42) chk_reset |-> !tdir && gpo == 8'h00 && !tsnd)
		else report_plain("tdir, gpo or tsnd not at reset value");

	// read data lands on td while the controller drives it
	assert property (@(posedge clk42) chk_rd |-> tdir)
		else report_plain("tdir low while td was sampled");
	assert property (@(posedge clk42) chk_rd |-> td == exp_byte)
		else report_value(test_name, $sampled(exp_byte), $sampled(td));

	assert property (@(posedge clk42) chk_gpo |-> gpo == exp_byte)
		else report_value(test_name, $sampled(exp_byte), $sampled(gpo));

	// nobody answers, bus must stay released
	assert property (@(posedge clk42) chk_quiet |-> !tdir)
		else report_plain("tdir went high on an unmapped access");

	// controller lets go of td shortly after the strobe rises
	assert property (@(posedge clk42) chk_release |-> !tdir)
		else report_plain("tdir still high after the read strobe ended");

	assert property (@(posedge clk42) chk_pwm |-> high_cnt == exp_cnt)
		else report_value(test_name, $sampled(exp_cnt), $sampled(high_cnt));

	// ----------------------------------------------------------
	// stimulus helpers
	// ----------------------------------------------------------

	// galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [15:0] take_bits(input int unsigned n);
		logic [15:0] v;
		v = '0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// called and returns on a falling edge
	task automatic slot_cycle(input logic io, input logic wr, input logic sel_n,
		input logic [15:0] addr, input logic [7:0] wdata, input chk_t chk,
		input logic [7:0] expv);
		ta       = addr;
		exp_byte = expv;
		if (io) begin
			n_iorq = 1'b0;
		end else begin
			n_merq  = 1'b0;
			n_sltsl = sel_n;
		end
		if (wr) begin
			td_drv    = wdata;
			td_drv_en = 1'b1;
			n_wr      = 1'b0;
		end else begin
			n_rd = 1'b0;
		end
		chk_quiet = (chk == CHK_QUIET);
		repeat (STROBE_CYCLES - 1) @(negedge clk42);
		// last low cycle
		chk_rd  = (chk == CHK_READ);
		chk_gpo = (chk == CHK_GPO);
		@(negedge clk42);
		chk_rd    = 1'b0;
		chk_gpo   = 1'b0;
		n_rd      = 1'b1;
		n_wr      = 1'b1;
		n_iorq    = 1'b1;
		n_merq    = 1'b1;
		n_sltsl   = 1'b1;
		td_drv_en = 1'b0;
		// drive must also end during the gap
		repeat (RELEASE_CYCLES) @(negedge clk42);
		chk_release = 1'b1;
		repeat (IDLE_CYCLES - RELEASE_CYCLES) @(negedge clk42);
		chk_release = 1'b0;
		chk_quiet   = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data,
		input chk_t chk);
		slot_cycle(1'b1, 1'b1, 1'b1, addr, data, chk, data);
	endtask

	task automatic io_read(input logic [15:0] addr, input logic [7:0] expv,
		input chk_t chk);
		slot_cycle(1'b1, 1'b0, 1'b1, addr, 8'h00, chk, expv);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		slot_cycle(1'b0, 1'b1, 1'b0, addr, data, CHK_NONE, data);
	endtask

	task automatic mem_read(input logic [15:0] addr, input logic sel_n,
		input logic [7:0] expv, input chk_t chk);
		slot_cycle(1'b0, 1'b0, sel_n, addr, 8'h00, chk, expv);
	endtask

	// high cycles over one full period, mid-cycle samples
	task automatic measure_pwm(input logic [7:0] level);
		high_cnt = 0;
		repeat (PWM_PERIOD) begin
			@(negedge clk42);
			high_cnt = high_cnt + tsnd;
		end
		exp_cnt = level * TICK_DIV_TB;
		chk_pwm = 1'b1;
		@(negedge clk42);
		chk_pwm = 1'b0;
	endtask

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------

	initial begin
		logic [15:0] a;
		logic [7:0]  d;
		logic [7:0]  lvl [3];
		w_n_reset   = 1'b0;
		ta          = '0;
		n_sltsl     = 1'b1;
		n_merq      = 1'b1;
		n_iorq      = 1'b1;
		n_rd        = 1'b1;
		n_wr        = 1'b1;
		gpi         = '0;
		td_drv      = '0;
		td_drv_en   = 1'b0;
		chk_reset   = 1'b0;
		chk_rd      = 1'b0;
		chk_gpo     = 1'b0;
		chk_quiet   = 1'b0;
		chk_pwm     = 1'b0;
		chk_release = 1'b0;
		exp_byte    = '0;
		exp_cnt     = 0;
		high_cnt    = 0;
		lfsr        = 16'd2;
		test_name   = "reset";

		// reset values, then one silent PWM period
		@(negedge clk42);
		chk_reset = 1'b1;
		repeat (RESET_CYCLES - 1) @(negedge clk42);
		w_n_reset = 1'b1;
		test_name = "reset tsnd";
		measure_pwm(8'd0);
		chk_reset = 1'b0;

		// ram fill, then readback against the mirrored model
		test_name = "ram";
		for (int i = 0; i < 16; i++) begin
			a = RAM_BASE_TB | take_bits(14);
			d = 8'(take_bits(8));
			ram_addr_q[i] = a;
			ram_model[a[9:0]] = d;
			mem_write(a, d);
		end
		for (int i = 0; i < 16; i++) begin
			a = ram_addr_q[i];
			mem_read(a, 1'b0, ram_model[a[9:0]], CHK_READ);
		end

		// gpio, upper address byte is don't care
		for (int i = 0; i < 2; i++) begin
			test_name = "gpio write";
			d = 8'(take_bits(8));
			a = {8'(take_bits(8)), PORT_GPIO_TB};
			io_write(a, d, CHK_GPO);
			test_name = "gpio read";
			gpi = 8'(take_bits(8));
			a = {8'(take_bits(8)), PORT_GPIO_TB};
			io_read(a, gpi, CHK_READ);
		end

		// unmapped accesses
		test_name = "unselected slot";
		mem_read(RAM_BASE_TB | take_bits(14), 1'b1, 8'h00, CHK_QUIET);
		test_name = "outside window";
		a = take_bits(16);
		// top bits 00 or 11, never page 1
		a[14] = a[15];
		mem_read(a, 1'b0, 8'h00, CHK_QUIET);
		test_name = "unmapped port";
		d = 8'(take_bits(8));
		if (d == PORT_GPIO_TB || d == PORT_SOUND_TB) begin
			d = d ^ 8'h80;
		end
		io_read({8'(take_bits(8)), d}, 8'h00, CHK_QUIET);

		// sound level readback and duty
		lvl[0] = 8'd0;
		lvl[1] = 8'd128;
		lvl[2] = 8'(take_bits(8));
		for (int i = 0; i < 3; i++) begin
			test_name = "sound readback";
			io_write({8'h00, PORT_SOUND_TB}, lvl[i], CHK_NONE);
			io_read({8'h00, PORT_SOUND_TB}, lvl[i], CHK_READ);
			test_name = "sound pwm";
			// new level latched at the next boundary
			repeat (PWM_PERIOD) @(negedge clk42);
			measure_pwm(lvl[i]);
		end

		$display("Regression passed");
		$finish;
	end

endmodule

/* sources.f */
msx_bus_pkg.sv
cart_map_pkg.sv
cart_bus_ctrl.sv
cart_ram.sv
cart_io_regs.sv
pwm_dac.sv
tangcart_top.sv
tb_tangcart.sv

/* Makefile */
# Verilator flow for the tangcart testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tb_tangcart -f sources.f

# pass or fail is decided by the pass line in the log
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tangcart \
		-f sources.f -o tb_tangcart
	./obj_dir/tb_tangcart | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
